// ==== design/nts_dispatch_macros.svh ====
`ifndef NTS_DISPATCH_MACROS_SVH
`define NTS_DISPATCH_MACROS_SVH

// --------------------
// Engine bank
// --------------------

// Number of engines behind the dispatcher, 1 to 8
`define NTS_ENGINES 2

// Cycles an engine stays busy after the last word of a frame
// Must be at least 2
`define NTS_ENGINE_DELAY 8

// --------------------
// Frame buffer
// --------------------

// Depth of the one-frame buffer in 64-bit words
`define NTS_FRAME_WORDS 16

`endif

// ==== design/nts_bus_pkg.sv ====
package nts_bus_pkg;

  // --------------------
  // Frame stream
  // --------------------

  // One frame word with its strobes
  // bytes is zero on every word except the last
  typedef struct packed {
    logic        start;
    logic        valid;
    logic [3:0]  bytes;
    logic [63:0] data;
  } nts_word_t;

  // --------------------
  // Engine lanes
  // --------------------

  // Input lane of one engine
  // Unselected lanes keep fifo_empty high
  typedef struct packed {
    logic      fifo_empty;
    nts_word_t word;
  } nts_dispatch_t;

endpackage

// ==== design/nts_engine_pkg.sv ====
package nts_engine_pkg;

  // --------------------
  // Time protocol header
  // --------------------

  // First 64 bits of the time packet, MSB first
  typedef struct packed {
    logic [1:0]  leap;
    logic [2:0]  version;
    logic [2:0]  mode;
    logic [7:0]  stratum;
    logic [7:0]  poll;
    logic [7:0]  precision;
    logic [31:0] root_delay;
  } nts_hdr_t;

  // Header view for decode, raw view for the checksum
  typedef union packed {
    nts_hdr_t    hdr;
    logic [63:0] raw;
  } nts_first_word_u;

  // --------------------
  // Engine digest
  // --------------------

  typedef struct packed {
    logic [2:0]  version;
    logic [2:0]  mode;
    // Up to 16 words per frame
    logic [4:0]  words;
    // Byte count of the final word
    logic [3:0]  bytes;
    // XOR of all data words
    logic [63:0] checksum;
  } nts_result_t;

endpackage

// ==== design/nts_frame_buffer.sv ====
`timescale 1ns/1ps
`include "nts_dispatch_macros.svh"

module nts_frame_buffer
  import nts_bus_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_areset,
  input  logic        i_rx_valid,
  input  logic        i_rx_last,
  input  logic [3:0]  i_rx_bytes,
  input  logic [63:0] i_rx_data,
  input  logic        i_mux_busy,
  input  logic        i_mux_ready,
  output logic        o_rx_busy,
  output nts_word_t   o_word,
  output logic        o_discard
);

  localparam int DEPTH = `NTS_FRAME_WORDS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] PTR_MAX = PTR_W'(DEPTH - 1);

  localparam logic [2:0] ST_LOAD    = 3'd0;
  localparam logic [2:0] ST_WAIT    = 3'd1;
  localparam logic [2:0] ST_START   = 3'd2;
  localparam logic [2:0] ST_STREAM  = 3'd3;
  localparam logic [2:0] ST_DISCARD = 3'd4;

  logic [2:0]       state;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] last_ptr;
  logic [3:0]       last_bytes;
  logic [63:0]      mem [DEPTH];
  logic             rd_last;

  assign rd_last   = (rd_ptr == last_ptr);
  assign o_rx_busy = (state != ST_LOAD);
  assign o_discard = (state == ST_DISCARD);

  // --------------------
  // Frame storage
  // --------------------

  always_ff @(posedge i_clk) begin
    if (state == ST_LOAD && i_rx_valid) begin
      mem[wr_ptr] <= i_rx_data;
    end
  end

  // --------------------
  // Control FSM
  // --------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state      <= ST_LOAD;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      last_ptr   <= '0;
      last_bytes <= '0;
    end else begin
      case (state)
        ST_LOAD: begin
          if (i_rx_valid) begin
            if (i_rx_last) begin
              last_ptr   <= wr_ptr;
              // A zero count would hide the end of frame from the engine
              last_bytes <= (i_rx_bytes == 4'd0) ? 4'd8 : i_rx_bytes;
              state      <= ST_WAIT;
            end else if (wr_ptr != PTR_MAX) begin
              wr_ptr <= wr_ptr + 1'b1;
            end
          end
        end
        // Hold until the mux has picked an engine
        ST_WAIT: begin
          if (!i_mux_busy) begin
            state <= ST_START;
          end
        end
        ST_START: begin
          rd_ptr <= '0;
          state  <= ST_STREAM;
        end
        ST_STREAM: begin
          if (i_mux_ready) begin
            if (rd_last) begin
              state <= ST_DISCARD;
            end else begin
              rd_ptr <= rd_ptr + 1'b1;
            end
          end
        end
        ST_DISCARD: begin
          wr_ptr <= '0;
          state  <= ST_LOAD;
        end
        default: state <= ST_LOAD;
      endcase
    end
  end

  // Word and strobes toward the mux
  always_comb begin
    o_word       = '0;
    o_word.start = (state == ST_START);
    if (state == ST_STREAM && i_mux_ready) begin
      o_word.valid = 1'b1;
      o_word.data  = mem[rd_ptr];
      o_word.bytes = rd_last ? last_bytes : 4'd0;
    end
  end

  a_start_not_valid: assert property (
    @(posedge i_clk) disable iff (i_areset)
    !(o_word.start && o_word.valid));

  a_discard_after_last: assert property (
    @(posedge i_clk) disable iff (i_areset)
    o_discard |-> $past(o_word.valid) && ($past(o_word.bytes) != 4'd0));

endmodule

// ==== design/nts_dispatcher_mux.sv ====
`timescale 1ns/1ps
`include "nts_dispatch_macros.svh"

module nts_dispatcher_mux
  import nts_bus_pkg::*;
(
  input  logic                              i_clk,
  input  logic                              i_areset,
  input  nts_word_t                         i_word,
  input  logic                              i_discard,
  input  logic [`NTS_ENGINES-1:0]           i_dispatch_busy,
  input  logic [`NTS_ENGINES-1:0]           i_dispatch_ready,
  output logic                              o_busy,
  output logic                              o_ready,
  output nts_dispatch_t [`NTS_ENGINES-1:0]  o_dispatch
);

  localparam int ENGINES = `NTS_ENGINES;
  localparam int IDX_W   = (ENGINES > 1) ? $clog2(ENGINES) : 1;

  localparam logic MUX_SEARCH = 1'b0;
  localparam logic MUX_REMAIN = 1'b1;

  // --------------------
  // Search registers
  // --------------------

  logic [ENGINES-1:0] idle_reg;
  logic               found_new;
  logic               found_reg;
  logic [IDX_W-1:0]   index_new;
  logic [IDX_W-1:0]   index_reg;

  // --------------------
  // Select registers
  // --------------------

  logic               mux_state;
  logic [IDX_W-1:0]   sel_index;
  // High from start until discard
  logic               frame_open;

  assign o_busy = (mux_state != MUX_REMAIN);

  // Lowest idle index wins, so scan from the top down
  always_comb begin
    found_new = 1'b0;
    index_new = '0;
    for (int i = ENGINES - 1; i >= 0; i--) begin
      if (idle_reg[i]) begin
        found_new = 1'b1;
        index_new = IDX_W'(i);
      end
    end
  end

  // Route the stream to the selected lane only
  always_comb begin
    o_ready = 1'b0;
    for (int i = 0; i < ENGINES; i++) begin
      o_dispatch[i]            = '0;
      o_dispatch[i].fifo_empty = 1'b1;
    end
    if (mux_state == MUX_REMAIN) begin
      o_ready                          = i_dispatch_ready[sel_index];
      o_dispatch[sel_index].word       = i_word;
      o_dispatch[sel_index].fifo_empty = i_discard;
    end
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      idle_reg   <= '0;
      found_reg  <= 1'b0;
      index_reg  <= '0;
      mux_state  <= MUX_SEARCH;
      sel_index  <= '0;
      frame_open <= 1'b0;
    end else begin
      idle_reg  <= ~i_dispatch_busy;
      found_reg <= found_new;
      index_reg <= index_new;

      case (mux_state)
        MUX_SEARCH: begin
          if (found_reg) begin
            mux_state <= MUX_REMAIN;
            sel_index <= index_reg;
          end
        end
        MUX_REMAIN: begin
          // Frame done, look for the next idle engine
          if (i_discard) begin
            mux_state  <= MUX_SEARCH;
            frame_open <= 1'b0;
          end else if (i_word.start) begin
            frame_open <= 1'b1;
          end else if (!frame_open && found_reg) begin
            // No frame yet, keep to the lowest idle engine
            sel_index <= index_reg;
          end
        end
        default: mux_state <= MUX_SEARCH;
      endcase
    end
  end

  // A frame only starts on an engine that was idle
  a_start_idle: assert property (
    @(posedge i_clk) disable iff (i_areset)
    i_word.start |-> (mux_state == MUX_REMAIN) && idle_reg[sel_index]);

endmodule

// ==== design/nts_engine_sink.sv ====
`timescale 1ns/1ps
`include "nts_dispatch_macros.svh"

module nts_engine_sink
  import nts_bus_pkg::*;
  import nts_engine_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_areset,
  input  nts_dispatch_t i_lane,
  output logic          o_busy,
  output logic          o_ready,
  output logic          o_result_valid,
  output nts_result_t   o_result
);

  localparam int DELAY = `NTS_ENGINE_DELAY;
  localparam int CNT_W = $clog2(DELAY + 1);

  logic             lane_start;
  logic             lane_valid;
  logic             lane_last;
  nts_first_word_u  first_word;

  logic             busy_reg;
  logic             counting;
  logic [CNT_W-1:0] delay_cnt;
  logic             result_valid;

  logic [4:0]       word_cnt;
  logic [63:0]      checksum;
  logic [2:0]       version;
  logic [2:0]       mode;
  logic [3:0]       last_bytes;

  assign lane_start = i_lane.word.start & ~i_lane.fifo_empty;
  assign lane_valid = i_lane.word.valid & ~i_lane.fifo_empty;
  assign lane_last  = lane_valid && (i_lane.word.bytes != 4'd0);

  assign first_word.raw = i_lane.word.data;

  // Busy already in the start cycle so the mux search sees it in time
  assign o_busy         = busy_reg | lane_start;
  assign o_ready        = ~counting;
  assign o_result_valid = result_valid;

  assign o_result.version  = version;
  assign o_result.mode     = mode;
  assign o_result.words    = word_cnt;
  assign o_result.bytes    = last_bytes;
  assign o_result.checksum = checksum;

  // --------------------
  // Busy and countdown
  // --------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      busy_reg     <= 1'b0;
      counting     <= 1'b0;
      delay_cnt    <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= 1'b0;
      if (lane_start) begin
        busy_reg <= 1'b1;
      end
      if (lane_last) begin
        counting  <= 1'b1;
        delay_cnt <= CNT_W'(DELAY - 1);
      end else if (counting) begin
        if (delay_cnt <= CNT_W'(1)) begin
          counting     <= 1'b0;
          busy_reg     <= 1'b0;
          result_valid <= 1'b1;
        end else begin
          delay_cnt <= delay_cnt - 1'b1;
        end
      end
    end
  end

  // --------------------
  // Frame digest
  // --------------------

  always_ff @(posedge i_clk) begin
    if (lane_start) begin
      word_cnt <= '0;
      checksum <= '0;
    end else if (lane_valid) begin
      checksum <= checksum ^ first_word.raw;
      word_cnt <= word_cnt + 1'b1;
      // Header fields come from word 0 only
      if (word_cnt == 5'd0) begin
        version <= first_word.hdr.version;
        mode    <= first_word.hdr.mode;
      end
      if (lane_last) begin
        last_bytes <= i_lane.word.bytes;
      end
    end
  end

  a_no_valid_when_empty: assert property (
    @(posedge i_clk) disable iff (i_areset)
    i_lane.fifo_empty |-> !i_lane.word.valid);

endmodule

// ==== design/nts_dispatch_top.sv ====
`timescale 1ns/1ps
`include "nts_dispatch_macros.svh"

module nts_dispatch_top
  import nts_bus_pkg::*;
  import nts_engine_pkg::*;
(
  input  logic                            i_clk,
  input  logic                            i_areset,
  input  logic                            i_rx_valid,
  input  logic                            i_rx_last,
  input  logic [3:0]                      i_rx_bytes,
  input  logic [63:0]                     i_rx_data,
  output logic                            o_rx_busy,
  output logic [`NTS_ENGINES-1:0]         o_result_valid,
  output nts_result_t [`NTS_ENGINES-1:0]  o_result
);

  localparam int ENGINES = `NTS_ENGINES;

  nts_word_t                    buf_word;
  logic                         buf_discard;
  logic                         mux_busy;
  logic                         mux_ready;
  nts_dispatch_t [ENGINES-1:0]  lanes;
  logic [ENGINES-1:0]           eng_busy;
  logic [ENGINES-1:0]           eng_ready;

  nts_frame_buffer buffer_i (
    .i_clk       (i_clk),
    .i_areset    (i_areset),
    .i_rx_valid  (i_rx_valid),
    .i_rx_last   (i_rx_last),
    .i_rx_bytes  (i_rx_bytes),
    .i_rx_data   (i_rx_data),
    .i_mux_busy  (mux_busy),
    .i_mux_ready (mux_ready),
    .o_rx_busy   (o_rx_busy),
    .o_word      (buf_word),
    .o_discard   (buf_discard)
  );

  nts_dispatcher_mux mux_i (
    .i_clk            (i_clk),
    .i_areset         (i_areset),
    .i_word           (buf_word),
    .i_discard        (buf_discard),
    .i_dispatch_busy  (eng_busy),
    .i_dispatch_ready (eng_ready),
    .o_busy           (mux_busy),
    .o_ready          (mux_ready),
    .o_dispatch       (lanes)
  );

  // One engine per dispatch lane
  for (genvar g = 0; g < ENGINES; g++) begin : g_engine
    nts_engine_sink engine_i (
      .i_clk          (i_clk),
      .i_areset       (i_areset),
      .i_lane         (lanes[g]),
      .o_busy         (eng_busy[g]),
      .o_ready        (eng_ready[g]),
      .o_result_valid (o_result_valid[g]),
      .o_result       (o_result[g])
    );
  end

endmodule

// ==== verification/tb_nts_dispatch.sv ====
`timescale 1ns/1ps
`include "nts_dispatch_macros.svh"

module tb_nts_dispatch
  import nts_engine_pkg::*;
;

  localparam int BUSY_TIMEOUT   = 100;
  localparam int RESULT_TIMEOUT = 100;

  logic                           i_clk = 1'b0;
  logic                           i_areset;
  logic                           i_rx_valid;
  logic                           i_rx_last;
  logic [3:0]                     i_rx_bytes;
  logic [63:0]                    i_rx_data;
  logic                           o_rx_busy;
  logic [`NTS_ENGINES-1:0]        o_result_valid;
  nts_result_t [`NTS_ENGINES-1:0] o_result;

  // Words of the frame being prepared or sent
  logic [63:0] frame_data [`NTS_FRAME_WORDS];

  int mismatch_count = 0;
  int timeout_count  = 0;

  nts_dispatch_top dut_i (
    .i_clk          (i_clk),
    .i_areset       (i_areset),
    .i_rx_valid     (i_rx_valid),
    .i_rx_last      (i_rx_last),
    .i_rx_bytes     (i_rx_bytes),
    .i_rx_data      (i_rx_data),
    .o_rx_busy      (o_rx_busy),
    .o_result_valid (o_result_valid),
    .o_result       (o_result)
  );

  always #10 i_clk = ~i_clk;

  // --------------------
  // Compare tasks
  // --------------------

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
      mismatch_count++;
    end
  endtask

  task automatic compare_result(input string name, input nts_result_t exp,
                                input nts_result_t act);
    if (exp !== act) begin
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      mismatch_count++;
    end
  endtask

  // --------------------
  // Stimulus helpers
  // --------------------

  task automatic fill_frame(input int len);
    for (int i = 0; i < len; i++) begin
      frame_data[i] = {$urandom, $urandom};
    end
  endtask

  // Version sits in bits 61:59 and mode in 58:56, after the 2-bit leap field
  task automatic set_header(input logic [2:0] version, input logic [2:0] mode);
    frame_data[0][61:59] = version;
    frame_data[0][58:56] = mode;
  endtask

  function automatic nts_result_t expected_result(input int len, input logic [3:0] last_bytes);
    nts_result_t res;
    res          = '0;
    res.version  = frame_data[0][61:59];
    res.mode     = frame_data[0][58:56];
    res.words    = 5'(len);
    res.bytes    = last_bytes;
    for (int i = 0; i < len; i++) begin
      res.checksum = res.checksum ^ frame_data[i];
    end
    return res;
  endfunction

  task automatic send_frame(input int len, input logic [3:0] last_bytes);
    int cycles;
    cycles = 0;
    @(negedge i_clk);
    while (o_rx_busy && cycles < BUSY_TIMEOUT) begin
      @(negedge i_clk);
      cycles++;
    end
    if (o_rx_busy) begin
      $display("timeout: frame buffer still busy after %0d cycles", BUSY_TIMEOUT);
      timeout_count++;
    end else begin
      for (int i = 0; i < len; i++) begin
        @(posedge i_clk);
        i_rx_valid <= 1'b1;
        i_rx_data  <= frame_data[i];
        i_rx_last  <= (i == len - 1);
        i_rx_bytes <= (i == len - 1) ? last_bytes : 4'd0;
      end
      @(posedge i_clk);
      i_rx_valid <= 1'b0;
      i_rx_last  <= 1'b0;
      i_rx_bytes <= 4'd0;
      i_rx_data  <= '0;
    end
  endtask

  task automatic wait_result(input int engine, output nts_result_t res, output bit seen);
    int cycles;
    cycles = 0;
    seen   = 1'b0;
    res    = '0;
    while (!seen && cycles < RESULT_TIMEOUT) begin
      @(negedge i_clk);
      if (o_result_valid[engine]) begin
        seen = 1'b1;
        res  = o_result[engine];
      end
      cycles++;
    end
    if (!seen) begin
      $display("timeout: engine %0d gave no result within %0d cycles", engine, RESULT_TIMEOUT);
      timeout_count++;
    end
  endtask

  task automatic expect_result(input int engine, input nts_result_t exp);
    nts_result_t res;
    bit          seen;
    wait_result(engine, res, seen);
    if (seen) begin
      compare_result($sformatf("o_result[%0d]", engine), exp, res);
    end
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic test_reset_state();
    repeat (10) begin
      @(negedge i_clk);
      compare_bit("o_rx_busy", 1'b0, o_rx_busy);
      for (int e = 0; e < `NTS_ENGINES; e++) begin
        compare_bit($sformatf("o_result_valid[%0d]", e), 1'b0, o_result_valid[e]);
      end
    end
  endtask

  task automatic test_single_frame();
    nts_result_t exp;
    fill_frame(5);
    exp = expected_result(5, 4'd3);
    send_frame(5, 4'd3);
    expect_result(0, exp);
  endtask

  // Engine 0 is still counting down when the second frame is dispatched
  task automatic test_engine_select();
    nts_result_t exp_a;
    nts_result_t exp_b;
    fill_frame(5);
    exp_a = expected_result(5, 4'd5);
    send_frame(5, 4'd5);
    fill_frame(4);
    exp_b = expected_result(4, 4'd8);
    fork
      send_frame(4, 4'd8);
      expect_result(0, exp_a);
    join
    expect_result(1, exp_b);
  endtask

  task automatic test_reuse_after_idle();
    nts_result_t exp;
    fill_frame(3);
    exp = expected_result(3, 4'd6);
    send_frame(3, 4'd6);
    expect_result(0, exp);
  endtask

  task automatic test_header_decode();
    nts_result_t exp;
    logic [2:0]  versions [3];
    logic [2:0]  modes [3];
    versions = '{3'd4, 3'd3, 3'd2};
    modes    = '{3'd3, 3'd4, 3'd1};
    for (int k = 0; k < 3; k++) begin
      fill_frame(2 + k);
      set_header(versions[k], modes[k]);
      exp = expected_result(2 + k, 4'd4);
      send_frame(2 + k, 4'd4);
      expect_result(0, exp);
    end
    // One-word frame, the checksum is the word itself
    fill_frame(1);
    set_header(3'd7, 3'd5);
    exp          = '0;
    exp.version  = 3'd7;
    exp.mode     = 3'd5;
    exp.words    = 5'd1;
    exp.bytes    = 4'd8;
    exp.checksum = frame_data[0];
    send_frame(1, 4'd8);
    expect_result(0, exp);
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    void'($urandom(32'h3f7a));
    i_areset   = 1'b1;
    i_rx_valid = 1'b0;
    i_rx_last  = 1'b0;
    i_rx_bytes = 4'd0;
    i_rx_data  = '0;
    repeat (16) @(posedge i_clk);
    i_areset <= 1'b0;

    test_reset_state();
    test_single_frame();
    test_engine_select();
    test_reuse_after_idle();
    test_header_decode();

    repeat (5) @(negedge i_clk);
    $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== nts_dispatch.f ====
+incdir+design
design/nts_bus_pkg.sv
design/nts_engine_pkg.sv
design/nts_frame_buffer.sv
design/nts_dispatcher_mux.sv
design/nts_engine_sink.sv
design/nts_dispatch_top.sv
verification/tb_nts_dispatch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the NTS dispatch testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f nts_dispatch.f \
  --top-module tb_nts_dispatch \
  -o sim_nts_dispatch > build.log 2>&1 \
  && ./obj_dir/sim_nts_dispatch > sim.log 2>&1 \
  && grep -q "^STATUS: PASS$" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }
